// File: src/axi_pkg.sv
// AXI read channel types
package axi_pkg;

  // Field widths
  localparam int ID_W    = 4;
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 128;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // Packet widths on the link
  localparam int AR_PKT_W = ADDR_W + BURST_W + LEN_W + SIZE_W + ID_W;
  localparam int R_PKT_W  = DATA_W + RESP_W + 1 + ID_W;

  typedef logic [ID_W-1:0]    axi_id_t;
  typedef logic [ADDR_W-1:0]  axi_addr_t;
  typedef logic [DATA_W-1:0]  axi_data_t;
  typedef logic [LEN_W-1:0]   axi_len_t;
  typedef logic [SIZE_W-1:0]  axi_size_t;
  typedef logic [BURST_W-1:0] axi_burst_t;
  typedef logic [RESP_W-1:0]  axi_resp_t;

  // {addr, burst, len, size, id}
  typedef logic [AR_PKT_W-1:0] ar_pkt_t;

  // {data, resp, last, id}
  typedef logic [R_PKT_W-1:0] r_pkt_t;

endpackage

// File: src/ll_pkg.sv
// Logic link constants
package ll_pkg;

  // One PHY lane
  localparam int PHY_W = 80;

  // Transmit lane bit positions
  localparam int TX_PUSH_BIT = 0;
  localparam int TX_PKT_LSB  = 1;
  localparam int TX_CRED_BIT = 50;

  // Receive word positions, rx_phy1 sits above rx_phy0
  localparam int RX_PUSH_BIT = 0;
  localparam int RX_PKT_LSB  = 1;
  localparam int RX_CRED_BIT = 136;

  localparam int CRED_W = 8;

  // Receive buffer entries
  localparam int RX_DEPTH = 128;

  // Cycles both directions must stay online
  localparam int LINK_UP_DELAY = 16;
  localparam int LINK_CNT_W    = $clog2(LINK_UP_DELAY + 1);

  typedef logic [PHY_W-1:0]      phy_word_t;
  typedef logic [CRED_W-1:0]     credit_t;
  typedef logic [LINK_CNT_W-1:0] link_cnt_t;

endpackage

// File: src/ll_link_fifo.sv
// Link buffer FIFO
module ll_link_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk_wr,
  input  logic             rst,
  input  logic             flush,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign empty   = (count == '0);
  assign full    = (count == FULL_CNT);
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk_wr) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk_wr) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/ll_online_sync.sv
// Link up qualifier
module ll_online_sync (
  input  logic clk_wr,
  input  logic rst,
  input  logic tx_online,
  input  logic rx_online,
  output logic link_up
);

  logic              both_online;
  ll_pkg::link_cnt_t online_cnt;

  assign both_online = tx_online & rx_online;

  // Saturating count of cycles with both sides online
  always_ff @(posedge clk_wr) begin
    if (rst || !both_online) begin
      online_cnt <= '0;
    end else if (online_cnt != ll_pkg::link_cnt_t'(ll_pkg::LINK_UP_DELAY)) begin
      online_cnt <= online_cnt + 1'b1;
    end
  end

  // Drops one cycle after either side goes offline
  assign link_up = (online_cnt == ll_pkg::link_cnt_t'(ll_pkg::LINK_UP_DELAY));

endmodule

// File: src/ll_transmit.sv
// Credit gated transmit channel
module ll_transmit (
  input  logic             clk_wr,
  input  logic             rst,
  input  logic             link_up,

  // User side
  input  logic             user_valid,
  input  axi_pkg::ar_pkt_t user_pkt,
  output logic             user_ready,

  // Link side
  input  logic             ar_credit,
  input  ll_pkg::credit_t  init_credit,
  output logic             ar_push,
  output axi_pkg::ar_pkt_t ar_pkt
);

  logic            take;
  logic            link_up_q;
  ll_pkg::credit_t credit_cnt;

  assign user_ready = link_up && (credit_cnt != '0);
  assign take       = user_valid && user_ready;

  //////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      link_up_q  <= 1'b0;
      credit_cnt <= '0;
    end else begin
      link_up_q <= link_up;
      if (!link_up) begin
        credit_cnt <= '0;
      end else if (!link_up_q) begin
        // Fresh link, start from the configured credit
        credit_cnt <= init_credit;
      end else begin
        case ({take, ar_credit})
          2'b10:   credit_cnt <= credit_cnt - 1'b1;
          2'b01:   credit_cnt <= credit_cnt + 1'b1;
          default: credit_cnt <= credit_cnt;
        endcase
      end
    end
  end

  //////////////////////////////
  // Output register

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ar_push <= 1'b0;
    end else begin
      ar_push <= take;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (take) begin
      ar_pkt <= user_pkt;
    end
  end

endmodule

// File: src/ll_receive.sv
// Receive channel with credit return
module ll_receive (
  input  logic            clk_wr,
  input  logic            rst,
  input  logic            link_up,

  // Link side
  input  logic            r_push,
  input  axi_pkg::r_pkt_t r_pkt,
  output logic            r_credit,

  // User side
  input  logic            user_ready,
  output logic            user_valid,
  output axi_pkg::r_pkt_t user_pkt
);

  logic fifo_flush;
  logic fifo_wr;
  logic fifo_pop;
  logic fifo_empty;
  logic fifo_full;

  // Drop everything buffered while the link is down
  assign fifo_flush = !link_up;

  // Beats arriving at a full buffer are discarded
  assign fifo_wr = link_up && r_push && !fifo_full;

  ll_link_fifo #(
    .WIDTH (axi_pkg::R_PKT_W),
    .DEPTH (ll_pkg::RX_DEPTH)
  ) u_rx_fifo (
    .clk_wr  (clk_wr),
    .rst     (rst),
    .flush   (fifo_flush),
    .wr_en   (fifo_wr),
    .wr_data (r_pkt),
    .rd_en   (fifo_pop),
    .rd_data (user_pkt),
    .empty   (fifo_empty),
    .full    (fifo_full)
  );

  assign user_valid = link_up && !fifo_empty;
  assign fifo_pop   = user_valid && user_ready;

  // One credit back to the remote per popped beat
  assign r_credit = fifo_pop;

endmodule

// File: src/ll_phy_packer.sv
// PHY lane packing
module ll_phy_packer (
  input  logic              clk_wr,
  input  logic              rst,

  // Transmit fields
  input  logic              ar_push,
  input  axi_pkg::ar_pkt_t  ar_pkt,
  input  logic              r_credit,
  output ll_pkg::phy_word_t tx_phy0,

  // Receive fields
  input  ll_pkg::phy_word_t rx_phy0,
  input  ll_pkg::phy_word_t rx_phy1,
  output logic              r_push,
  output axi_pkg::r_pkt_t   r_pkt,
  output logic              ar_credit
);

  ll_pkg::phy_word_t          tx_next;
  logic [2*ll_pkg::PHY_W-1:0] rx_word;

  //////////////////////////////
  // Transmit lane

  always_comb begin
    tx_next = '0;
    tx_next[ll_pkg::TX_PUSH_BIT] = ar_push;
    // Packet bits only carry data with a push
    if (ar_push) begin
      tx_next[ll_pkg::TX_PKT_LSB +: axi_pkg::AR_PKT_W] = ar_pkt;
    end
    tx_next[ll_pkg::TX_CRED_BIT] = r_credit;
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_next;
    end
  end

  //////////////////////////////
  // Receive lanes

  assign rx_word   = {rx_phy1, rx_phy0};
  assign r_push    = rx_word[ll_pkg::RX_PUSH_BIT];
  assign r_pkt     = rx_word[ll_pkg::RX_PKT_LSB +: axi_pkg::R_PKT_W];
  assign ar_credit = rx_word[ll_pkg::RX_CRED_BIT];

endmodule

// File: src/axi_rd_link_master.sv
// AXI read link master
module axi_rd_link_master (
  input  logic                clk_wr,
  input  logic                rst,

  // Link control
  input  logic                tx_online,
  input  logic                rx_online,
  input  ll_pkg::credit_t     init_ar_credit,

  // PHY lanes
  output ll_pkg::phy_word_t   tx_phy0,
  input  ll_pkg::phy_word_t   rx_phy0,
  input  ll_pkg::phy_word_t   rx_phy1,

  // AR channel
  input  axi_pkg::axi_id_t    user_arid,
  input  axi_pkg::axi_addr_t  user_araddr,
  input  axi_pkg::axi_len_t   user_arlen,
  input  axi_pkg::axi_size_t  user_arsize,
  input  axi_pkg::axi_burst_t user_arburst,
  input  logic                user_arvalid,
  output logic                user_arready,

  // R channel
  output axi_pkg::axi_id_t    user_rid,
  output axi_pkg::axi_data_t  user_rdata,
  output axi_pkg::axi_resp_t  user_rresp,
  output logic                user_rlast,
  output logic                user_rvalid,
  input  logic                user_rready
);

  logic              link_up;
  axi_pkg::ar_pkt_t  user_ar_pkt;
  axi_pkg::ar_pkt_t  ar_pkt;
  logic              ar_push;
  logic              ar_credit;
  axi_pkg::r_pkt_t   r_pkt;
  logic              r_push;
  logic              r_credit;
  axi_pkg::r_pkt_t   user_r_pkt;

  //////////////////////////////
  // User field mapping

  assign user_ar_pkt = {user_araddr, user_arburst, user_arlen, user_arsize, user_arid};
  assign {user_rdata, user_rresp, user_rlast, user_rid} = user_r_pkt;

  //////////////////////////////
  // Link blocks

  ll_online_sync u_online_sync (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .link_up   (link_up)
  );

  ll_transmit u_ar_transmit (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .link_up     (link_up),
    .user_valid  (user_arvalid),
    .user_pkt    (user_ar_pkt),
    .ar_credit   (ar_credit),
    .init_credit (init_ar_credit),
    .user_ready  (user_arready),
    .ar_push     (ar_push),
    .ar_pkt      (ar_pkt)
  );

  ll_receive u_r_receive (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .link_up    (link_up),
    .r_push     (r_push),
    .r_pkt      (r_pkt),
    .user_ready (user_rready),
    .user_valid (user_rvalid),
    .user_pkt   (user_r_pkt),
    .r_credit   (r_credit)
  );

  ll_phy_packer u_phy_packer (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .ar_push   (ar_push),
    .ar_pkt    (ar_pkt),
    .r_credit  (r_credit),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .tx_phy0   (tx_phy0),
    .r_push    (r_push),
    .r_pkt     (r_pkt),
    .ar_credit (ar_credit)
  );

endmodule

// File: test/axi_rd_checker.sv
// AXI read port checker
module axi_rd_checker (
  input  logic                clk_wr,
  input  logic                rst,
  input  ll_pkg::phy_word_t   tx_phy0,

  // AR channel
  input  axi_pkg::axi_id_t    user_arid,
  input  axi_pkg::axi_addr_t  user_araddr,
  input  axi_pkg::axi_len_t   user_arlen,
  input  axi_pkg::axi_size_t  user_arsize,
  input  axi_pkg::axi_burst_t user_arburst,
  input  logic                user_arvalid,
  input  logic                user_arready,

  // R channel
  input  axi_pkg::axi_id_t    user_rid,
  input  axi_pkg::axi_data_t  user_rdata,
  input  axi_pkg::axi_resp_t  user_rresp,
  input  logic                user_rlast,
  input  logic                user_rvalid,
  input  logic                user_rready,

  // Counts for the closing report
  output int                  errors,
  output int                  beats_popped,
  output int                  credits_seen,
  output int                  ar_pending,
  output int                  r_pending
);

  // AR field offsets on tx_phy0, id lowest and address on top
  localparam int ARID_LSB    = ll_pkg::TX_PKT_LSB;
  localparam int ARSIZE_LSB  = ARID_LSB + axi_pkg::ID_W;
  localparam int ARLEN_LSB   = ARSIZE_LSB + axi_pkg::SIZE_W;
  localparam int ARBURST_LSB = ARLEN_LSB + axi_pkg::LEN_W;
  localparam int ARADDR_LSB  = ARBURST_LSB + axi_pkg::BURST_W;

  typedef struct packed {
    axi_pkg::axi_id_t    id;
    axi_pkg::axi_addr_t  addr;
    axi_pkg::axi_len_t   len;
    axi_pkg::axi_size_t  size;
    axi_pkg::axi_burst_t burst;
  } ar_req_t;

  ar_req_t          ar_q[$];
  axi_pkg::r_pkt_t  r_q[$];
  int               err_cnt = 0;
  int               pop_cnt = 0;
  int               cred_cnt = 0;

  assign errors       = err_cnt;
  assign beats_popped = pop_cnt;
  assign credits_seen = cred_cnt;
  assign ar_pending   = ar_q.size();
  assign r_pending    = r_q.size();

  // Beats the remote side has sent in order
  task automatic expect_r(input axi_pkg::r_pkt_t beat);
    r_q.push_back(beat);
  endtask

  // Buffered beats are lost when the link drops
  task automatic clear_r();
    r_q.delete();
  endtask

  task automatic compare_field(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // Compare on each rising edge

  always @(posedge clk_wr) begin
    ar_req_t            new_ar;
    ar_req_t            exp_ar;
    axi_pkg::r_pkt_t    exp_r;
    axi_pkg::axi_data_t e_data;
    axi_pkg::axi_resp_t e_resp;
    logic               e_last;
    axi_pkg::axi_id_t   e_id;
    if (!rst) begin
      compare_field("tx_phy0 unused bits",
                    128'(tx_phy0[ll_pkg::PHY_W-1:ll_pkg::TX_CRED_BIT+1]), 128'(0));
      if (tx_phy0[ll_pkg::TX_PUSH_BIT]) begin
        if (ar_q.size() == 0) begin
          $display("An AR packet left on tx_phy0 with no request accepted");
          err_cnt++;
        end else begin
          exp_ar = ar_q.pop_front();
          compare_field("tx_phy0 arid", 128'(tx_phy0[ARID_LSB +: axi_pkg::ID_W]),
                        128'(exp_ar.id));
          compare_field("tx_phy0 arsize", 128'(tx_phy0[ARSIZE_LSB +: axi_pkg::SIZE_W]),
                        128'(exp_ar.size));
          compare_field("tx_phy0 arlen", 128'(tx_phy0[ARLEN_LSB +: axi_pkg::LEN_W]),
                        128'(exp_ar.len));
          compare_field("tx_phy0 arburst", 128'(tx_phy0[ARBURST_LSB +: axi_pkg::BURST_W]),
                        128'(exp_ar.burst));
          compare_field("tx_phy0 araddr", 128'(tx_phy0[ARADDR_LSB +: axi_pkg::ADDR_W]),
                        128'(exp_ar.addr));
        end
      end
      if (tx_phy0[ll_pkg::TX_CRED_BIT]) begin
        cred_cnt++;
      end
      if (user_arvalid && user_arready) begin
        new_ar.id    = user_arid;
        new_ar.addr  = user_araddr;
        new_ar.len   = user_arlen;
        new_ar.size  = user_arsize;
        new_ar.burst = user_arburst;
        ar_q.push_back(new_ar);
      end
      if (user_rvalid && user_rready) begin
        pop_cnt++;
        if (r_q.size() == 0) begin
          $display("An R beat was popped that the remote side never sent");
          err_cnt++;
        end else begin
          exp_r = r_q.pop_front();
          {e_data, e_resp, e_last, e_id} = exp_r;
          compare_field("user_rid", 128'(user_rid), 128'(e_id));
          compare_field("user_rdata", 128'(user_rdata), 128'(e_data));
          compare_field("user_rresp", 128'(user_rresp), 128'(e_resp));
          compare_field("user_rlast", 128'(user_rlast), 128'(e_last));
        end
      end
    end
  end

endmodule

// File: test/tb_axi_rd_link_master.sv
// AXI read link master testbench
module tb_axi_rd_link_master;

  localparam int N_RANDOM    = 24;
  localparam int INIT_CRED   = 4;
  localparam int RELINK_CRED = 6;
  localparam int SHORT_WAIT  = 30;

  logic                clk_wr = 1'b0;
  logic                rst = 1'b1;
  logic                tx_online = 1'b0;
  logic                rx_online = 1'b0;
  ll_pkg::credit_t     init_ar_credit = ll_pkg::credit_t'(INIT_CRED);
  ll_pkg::phy_word_t   tx_phy0;
  ll_pkg::phy_word_t   rx_phy0 = '0;
  ll_pkg::phy_word_t   rx_phy1 = '0;
  axi_pkg::axi_id_t    user_arid = '0;
  axi_pkg::axi_addr_t  user_araddr = '0;
  axi_pkg::axi_len_t   user_arlen = '0;
  axi_pkg::axi_size_t  user_arsize = '0;
  axi_pkg::axi_burst_t user_arburst = '0;
  logic                user_arvalid = 1'b0;
  logic                user_arready;
  axi_pkg::axi_id_t    user_rid;
  axi_pkg::axi_data_t  user_rdata;
  axi_pkg::axi_resp_t  user_rresp;
  logic                user_rlast;
  logic                user_rvalid;
  logic                user_rready = 1'b0;

  // Remote side state
  axi_pkg::r_pkt_t     send_q[$];
  int                  remote_credit = ll_pkg::RX_DEPTH;
  int                  ar_cred_req = 0;
  logic                auto_ar_credit = 1'b0;
  logic                remote_hold = 1'b0;
  logic                rready_random = 1'b0;

  int                  tb_errors = 0;
  int                  chk_errors;
  int                  beats_popped;
  int                  credits_seen;
  int                  ar_pending;
  int                  r_pending;

  always #20 clk_wr = ~clk_wr;

  axi_rd_link_master u_dut (
    .clk_wr(clk_wr), .rst(rst), .tx_online(tx_online), .rx_online(rx_online),
    .init_ar_credit(init_ar_credit), .tx_phy0(tx_phy0), .rx_phy0(rx_phy0), .rx_phy1(rx_phy1),
    .user_arid(user_arid), .user_araddr(user_araddr), .user_arlen(user_arlen),
    .user_arsize(user_arsize), .user_arburst(user_arburst), .user_arvalid(user_arvalid),
    .user_arready(user_arready), .user_rid(user_rid), .user_rdata(user_rdata),
    .user_rresp(user_rresp), .user_rlast(user_rlast), .user_rvalid(user_rvalid),
    .user_rready(user_rready)
  );

  axi_rd_checker u_chk (
    .clk_wr(clk_wr), .rst(rst), .tx_phy0(tx_phy0),
    .user_arid(user_arid), .user_araddr(user_araddr), .user_arlen(user_arlen),
    .user_arsize(user_arsize), .user_arburst(user_arburst), .user_arvalid(user_arvalid),
    .user_arready(user_arready), .user_rid(user_rid), .user_rdata(user_rdata),
    .user_rresp(user_rresp), .user_rlast(user_rlast), .user_rvalid(user_rvalid),
    .user_rready(user_rready), .errors(chk_errors), .beats_popped(beats_popped),
    .credits_seen(credits_seen), .ar_pending(ar_pending), .r_pending(r_pending)
  );

  // Remote memory contents for one beat
  function automatic axi_pkg::axi_data_t ref_rdata(input axi_pkg::axi_id_t id,
                                                   input axi_pkg::axi_addr_t addr,
                                                   input axi_pkg::axi_len_t beat);
    axi_pkg::axi_addr_t beat_addr;
    beat_addr = addr + {20'd0, beat, 4'd0};
    return {beat_addr, ~addr, {20'hc3e1a, id, beat}, beat_addr ^ 32'h9e37_79b9};
  endfunction

  task automatic queue_burst(input axi_pkg::ar_pkt_t ar);
    axi_pkg::axi_addr_t  addr;
    axi_pkg::axi_burst_t burst;
    axi_pkg::axi_len_t   len;
    axi_pkg::axi_size_t  size;
    axi_pkg::axi_id_t    id;
    axi_pkg::r_pkt_t     beat;
    {addr, burst, len, size, id} = ar;
    for (int b = 0; b <= int'(len); b++) begin
      beat = {ref_rdata(id, addr, axi_pkg::axi_len_t'(b)), 2'b00, b == int'(len), id};
      send_q.push_back(beat);
      u_chk.expect_r(beat);
    end
  endtask

  //////////////////////////////
  // Remote side of the link

  always @(negedge clk_wr) begin
    logic [2*ll_pkg::PHY_W-1:0] word;
    word = '0;
    if (tx_phy0[ll_pkg::TX_PUSH_BIT]) begin
      queue_burst(tx_phy0[ll_pkg::TX_PKT_LSB +: axi_pkg::AR_PKT_W]);
      if (auto_ar_credit) begin
        ar_cred_req++;
      end
    end
    if (tx_phy0[ll_pkg::TX_CRED_BIT]) begin
      remote_credit++;
    end
    if (!remote_hold) begin
      // Never send a beat without a credit
      if (send_q.size() != 0 && remote_credit > 0 && $urandom_range(3, 0) != 0) begin
        word[ll_pkg::RX_PUSH_BIT] = 1'b1;
        word[ll_pkg::RX_PKT_LSB +: axi_pkg::R_PKT_W] = send_q.pop_front();
        remote_credit--;
      end
      if (ar_cred_req > 0) begin
        word[ll_pkg::RX_CRED_BIT] = 1'b1;
        ar_cred_req--;
      end
    end
    rx_phy0 = word[ll_pkg::PHY_W-1:0];
    rx_phy1 = word[2*ll_pkg::PHY_W-1:ll_pkg::PHY_W];
  end

  always @(negedge clk_wr) begin
    user_rready = rready_random && ($urandom_range(2, 0) != 0);
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic send_ar(input int max_wait, output logic taken);
    int waited;
    taken = 1'b0;
    waited = 0;
    @(negedge clk_wr);
    user_arid    = axi_pkg::axi_id_t'($urandom);
    user_araddr  = axi_pkg::axi_addr_t'($urandom) & 32'hffff_fff0;
    user_arlen   = axi_pkg::axi_len_t'($urandom_range(7, 0));
    user_arsize  = 3'd4;
    user_arburst = 2'd1;
    user_arvalid = 1'b1;
    while (!taken && waited < max_wait) begin
      @(posedge clk_wr);
      if (user_arready) begin
        taken = 1'b1;
      end else begin
        waited++;
      end
    end
    @(negedge clk_wr);
    user_arvalid = 1'b0;
  endtask

  // Offer requests until one is refused
  task automatic count_accepted(output int accepted);
    logic taken;
    accepted = 0;
    taken = 1'b1;
    while (taken && accepted < 64) begin
      send_ar(SHORT_WAIT, taken);
      if (taken) begin
        accepted++;
      end
    end
  endtask

  task automatic wait_arready(input logic level, input int max_wait);
    int waited;
    waited = 0;
    while (user_arready !== level && waited < max_wait) begin
      @(negedge clk_wr);
      waited++;
    end
    if (user_arready !== level) begin
      $display("Timed out waiting for user_arready to become %0b", level);
      tb_errors++;
    end
  endtask

  task automatic drain(input int max_wait);
    int waited;
    waited = 0;
    while ((send_q.size() != 0 || r_pending != 0 || ar_pending != 0) && waited < max_wait) begin
      @(negedge clk_wr);
      waited++;
    end
    if (send_q.size() != 0 || r_pending != 0 || ar_pending != 0) begin
      $display("Timed out waiting for outstanding beats to drain");
      tb_errors++;
    end
  endtask

  initial begin
    int   waited;
    int   accepted;
    logic taken;
    void'($urandom(72625));
    repeat (5) @(negedge clk_wr);
    rst = 1'b0;
    @(negedge clk_wr);
    check_value("tx_phy0", 128'(tx_phy0), 128'(0));
    check_value("user_arready", 128'(user_arready), 128'(0));
    check_value("user_rvalid", 128'(user_rvalid), 128'(0));

    ////////////////////////////// Link up needs both sides
    rx_online = 1'b1;
    repeat (2 * ll_pkg::LINK_UP_DELAY) begin
      @(negedge clk_wr);
      check_value("user_arready", 128'(user_arready), 128'(0));
    end
    rx_online = 1'b0;
    tx_online = 1'b1;
    repeat (2 * ll_pkg::LINK_UP_DELAY) begin
      @(negedge clk_wr);
      check_value("user_arready", 128'(user_arready), 128'(0));
    end
    rx_online = 1'b1;
    waited = 0;
    while (!user_arready && waited < 100) begin
      @(negedge clk_wr);
      waited++;
    end
    // link_up after the delay, then one cycle to load the credit
    if (!user_arready) begin
      $display("Timed out waiting for the link to come up");
      tb_errors++;
    end else if (waited != ll_pkg::LINK_UP_DELAY + 1) begin
      $display("Error: link up cycles got %h expected %h", waited,
               ll_pkg::LINK_UP_DELAY + 1);
      tb_errors++;
    end

    ////////////////////////////// Transmit credits
    count_accepted(accepted);
    check_value("accepted requests", 128'(accepted), 128'(INIT_CRED));
    repeat (2) begin
      @(posedge clk_wr);
      ar_cred_req = 1;
      count_accepted(accepted);
      check_value("accepted after one credit", 128'(accepted), 128'(1));
    end
    @(posedge clk_wr);
    ar_cred_req = INIT_CRED;
    auto_ar_credit = 1'b1;
    rready_random = 1'b1;

    ////////////////////////////// Random requests with back-pressure
    for (int i = 0; i < N_RANDOM; i++) begin
      send_ar(200, taken);
      if (!taken) begin
        $display("An AR request was not accepted while credits were available");
        tb_errors++;
      end
      repeat ($urandom_range(2, 0)) @(negedge clk_wr);
    end
    drain(5000);

    ////////////////////////////// Link drop with beats buffered
    @(posedge clk_wr);
    rready_random = 1'b0;
    repeat (2) begin
      send_ar(200, taken);
    end
    waited = 0;
    while ((send_q.size() != 0 || !user_rvalid) && waited < 200) begin
      @(negedge clk_wr);
      waited++;
    end
    if (send_q.size() != 0 || !user_rvalid) begin
      $display("Timed out waiting for beats to be buffered");
      tb_errors++;
    end
    repeat (4) @(negedge clk_wr);
    @(posedge clk_wr);
    remote_hold = 1'b1;
    send_q.delete();
    remote_credit = ll_pkg::RX_DEPTH;
    ar_cred_req = 0;
    auto_ar_credit = 1'b0;
    u_chk.clear_r();
    @(negedge clk_wr);
    rx_online = 1'b0;
    // A new credit value tells a reload apart from a kept count
    init_ar_credit = ll_pkg::credit_t'(RELINK_CRED);
    waited = 0;
    while ((user_arready || user_rvalid) && waited < 5) begin
      @(negedge clk_wr);
      waited++;
    end
    check_value("user_arready", 128'(user_arready), 128'(0));
    check_value("user_rvalid", 128'(user_rvalid), 128'(0));
    rx_online = 1'b1;
    @(posedge clk_wr);
    remote_hold = 1'b0;
    wait_arready(1'b1, 100);
    count_accepted(accepted);
    check_value("accepted after relink", 128'(accepted), 128'(RELINK_CRED));
    @(posedge clk_wr);
    ar_cred_req = INIT_CRED;
    auto_ar_credit = 1'b1;
    rready_random = 1'b1;
    drain(5000);
    repeat (4) @(negedge clk_wr);

    if (credits_seen != beats_popped) begin
      $display("The credits returned on tx_phy0 do not match the beats popped");
      tb_errors++;
    end
    $display("Done: %0d testbench errors, %0d checker errors, %0d beats, %0d credits",
             tb_errors, chk_errors, beats_popped, credits_seen);
    if (tb_errors + chk_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: axi_rd_link_master.f
src/axi_pkg.sv
src/ll_pkg.sv
src/ll_link_fifo.sv
src/ll_online_sync.sv
src/ll_transmit.sv
src/ll_receive.sv
src/ll_phy_packer.sv
src/axi_rd_link_master.sv
test/axi_rd_checker.sv
test/tb_axi_rd_link_master.sv

// File: Makefile
TOP = tb_axi_rd_link_master

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f axi_rd_link_master.f

sim:
	verilator --binary --timing --top-module $(TOP) -f axi_rd_link_master.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
